// File: rtl/tlb_pkg.sv
`default_nettype none

package tlb_pkg;

    // field widths
    typedef logic [18:0] vppn_t;
    typedef logic [9:0]  asid_t;
    typedef logic [19:0] ppn_t;
    typedef logic [5:0]  ps_t;
    typedef logic [1:0]  plv_t;
    typedef logic [1:0]  mat_t;
    typedef logic [4:0]  inv_op_t;

    // invtlb op codes
    localparam inv_op_t INV_ALL0         = 5'd0;
    localparam inv_op_t INV_ALL1         = 5'd1;
    localparam inv_op_t INV_G            = 5'd2;
    localparam inv_op_t INV_NG           = 5'd3;
    localparam inv_op_t INV_NG_ASID      = 5'd4;
    localparam inv_op_t INV_NG_ASID_VA   = 5'd5;
    localparam inv_op_t INV_G_OR_ASID_VA = 5'd6;

    // supported page sizes, as log2 of bytes
    localparam ps_t PS_4K = 6'd12;
    localparam ps_t PS_2M = 6'd21;

    typedef struct packed {
        ppn_t ppn;
        plv_t plv;
        mat_t mat;
        logic d;
        logic v;
    } tlb_page_t;

    // page0 is the even page, page1 the odd one
    typedef struct packed {
        logic      e;
        vppn_t     vppn;
        ps_t       ps;
        asid_t     asid;
        logic      g;
        tlb_page_t page0;
        tlb_page_t page1;
    } tlb_entry_t;

    typedef struct packed {
        vppn_t vppn;
        logic  va_bit12;
        asid_t asid;
    } tlb_search_req_t;

    typedef struct packed {
        logic found;
        ppn_t ppn;
        ps_t  ps;
        plv_t plv;
        mat_t mat;
        logic d;
        logic v;
    } tlb_search_rsp_t;

    // each set flag adds one condition an entry must meet to be cleared
    typedef struct packed {
        logic active;
        logic all;
        logic g_only;
        logic ng_only;
        logic chk_asid;
        logic chk_va;
        logic asid_or_g;
    } inv_cmd_t;

endpackage

`default_nettype wire

// File: rtl/tlb_wr_decode.sv
`timescale 1ns/100ps
`default_nettype none

module tlb_wr_decode import tlb_pkg::*; #(
    parameter  int TLBNUM = 16,
    localparam int IDX_W  = $clog2(TLBNUM)
) (
    input  logic              we,
    input  logic [IDX_W-1:0]  w_index,
    input  logic              inv_valid,
    input  inv_op_t           inv_op,
    output logic [TLBNUM-1:0] entry_we,
    output inv_cmd_t          inv_cmd
);
    // one-hot write enable
    always_comb begin
        for (int i = 0; i < TLBNUM; i++) begin
            entry_we[i] = we && (w_index == IDX_W'(i));
        end
    end

    always_comb begin
        inv_cmd = '0;
        case (inv_op)
            INV_ALL0, INV_ALL1: begin
                inv_cmd.all = 1'b1;
            end
            INV_G: begin
                inv_cmd.g_only = 1'b1;
            end
            INV_NG: begin
                inv_cmd.ng_only = 1'b1;
            end
            INV_NG_ASID: begin
                inv_cmd.ng_only  = 1'b1;
                inv_cmd.chk_asid = 1'b1;
            end
            INV_NG_ASID_VA: begin
                inv_cmd.ng_only  = 1'b1;
                inv_cmd.chk_asid = 1'b1;
                inv_cmd.chk_va   = 1'b1;
            end
            INV_G_OR_ASID_VA: begin
                inv_cmd.asid_or_g = 1'b1;
                inv_cmd.chk_va    = 1'b1;
            end
            default: begin
            end
        endcase
        // ops above 6 leave the table alone
        inv_cmd.active = inv_valid && (inv_op <= INV_G_OR_ASID_VA);
    end

    always_comb begin
        if (!$isunknown({we, inv_valid, inv_op})) begin
            assert #0 (!(we && inv_valid))
                else $error("tlb write and invtlb issued together");
            assert #0 (!inv_valid || inv_op <= INV_G_OR_ASID_VA)
                else $error("invtlb with illegal op %0d", inv_op);
        end
    end

endmodule

`default_nettype wire

// File: rtl/tlb_entry.sv
`timescale 1ns/100ps
`default_nettype none

module tlb_entry import tlb_pkg::*; (
    input  logic            aclk,
    input  logic            arst_n,
    input  logic            wr,
    input  tlb_entry_t      w_entry,
    input  inv_cmd_t        inv_cmd,
    input  tlb_search_req_t s0_req,
    input  tlb_search_req_t s1_req,
    output logic            s0_hit,
    output logic            s1_hit,
    output tlb_entry_t      entry
);
    logic      e_q;
    vppn_t     vppn_q;
    ps_t       ps_q;
    asid_t     asid_q;
    logic      g_q;
    tlb_page_t page0_q;
    tlb_page_t page1_q;

    logic      s0_asid_eq;
    logic      s1_asid_eq;
    logic      s0_va_ok;
    logic      s1_va_ok;
    logic      inv_hit;

    // 2M pages ignore vppn[8:0], bit 8 picks the odd half
    function automatic logic va_match(
        input vppn_t va,
        input vppn_t tag,
        input ps_t   ps
    );
        if (ps == PS_2M) begin
            return va[18:9] == tag[18:9];
        end
        return va == tag;
    endfunction

    assign s0_va_ok   = va_match(s0_req.vppn, vppn_q, ps_q);
    assign s1_va_ok   = va_match(s1_req.vppn, vppn_q, ps_q);
    assign s0_asid_eq = (s0_req.asid == asid_q);
    assign s1_asid_eq = (s1_req.asid == asid_q);

    assign s0_hit = e_q && (g_q || s0_asid_eq) && s0_va_ok;
    assign s1_hit = e_q && (g_q || s1_asid_eq) && s1_va_ok;

    // invtlb compares against the port 1 operands
    assign inv_hit = inv_cmd.active &&
                     (inv_cmd.all ||
                      ((!inv_cmd.g_only    || g_q) &&
                       (!inv_cmd.ng_only   || !g_q) &&
                       (!inv_cmd.chk_asid  || s1_asid_eq) &&
                       (!inv_cmd.asid_or_g || g_q || s1_asid_eq) &&
                       (!inv_cmd.chk_va    || s1_va_ok)));

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            e_q <= 1'b0;
        end else if (wr) begin
            e_q <= w_entry.e;
        end else if (inv_hit) begin
            e_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (wr) begin
            vppn_q  <= w_entry.vppn;
            ps_q    <= w_entry.ps;
            asid_q  <= w_entry.asid;
            g_q     <= w_entry.g;
            page0_q <= w_entry.page0;
            page1_q <= w_entry.page1;
        end
    end

    assign entry = '{
        e:     e_q,
        vppn:  vppn_q,
        ps:    ps_q,
        asid:  asid_q,
        g:     g_q,
        page0: page0_q,
        page1: page1_q
    };

    // a live entry must only ever hold a supported page size
    a_legal_ps: assert property (
        @(posedge aclk) disable iff (!arst_n)
        e_q |-> (ps_q == PS_4K || ps_q == PS_2M)
    ) else $error("valid tlb entry with page size %0d", ps_q);

endmodule

`default_nettype wire

// File: rtl/tlb_lookup_sel.sv
`timescale 1ns/100ps
`default_nettype none

module tlb_lookup_sel import tlb_pkg::*; #(
    parameter  int TLBNUM = 16,
    localparam int IDX_W  = $clog2(TLBNUM)
) (
    input  tlb_search_req_t  s0_req,
    input  tlb_search_req_t  s1_req,
    input  logic [TLBNUM-1:0] s0_hit,
    input  logic [TLBNUM-1:0] s1_hit,
    input  tlb_entry_t       entries [TLBNUM],
    input  logic [IDX_W-1:0] r_index,
    output tlb_search_rsp_t  s0_rsp,
    output logic [IDX_W-1:0] s0_index,
    output tlb_search_rsp_t  s1_rsp,
    output logic [IDX_W-1:0] s1_index,
    output tlb_entry_t       r_entry
);
    tlb_entry_t s0_ent;
    tlb_entry_t s1_ent;

    // hit vectors are one-hot, so OR-ing the indexes is enough
    function automatic logic [IDX_W-1:0] encode(input logic [TLBNUM-1:0] hit);
        logic [IDX_W-1:0] idx;
        idx = '0;
        for (int i = 0; i < TLBNUM; i++) begin
            if (hit[i]) begin
                idx = idx | IDX_W'(i);
            end
        end
        return idx;
    endfunction

    function automatic tlb_search_rsp_t make_rsp(
        input tlb_search_req_t req,
        input tlb_entry_t      ent,
        input logic            found
    );
        tlb_search_rsp_t rsp;
        logic            odd;
        tlb_page_t       page;
        odd  = (ent.ps == PS_2M) ? req.vppn[8] : req.va_bit12;
        page = odd ? ent.page1 : ent.page0;
        rsp  = '{
            found: 1'b1,
            ppn:   page.ppn,
            ps:    ent.ps,
            plv:   page.plv,
            mat:   page.mat,
            d:     page.d,
            v:     page.v
        };
        // miss returns all zero
        if (!found) begin
            rsp = '0;
        end
        return rsp;
    endfunction

    always_comb begin
        s0_ent = '0;
        s1_ent = '0;
        for (int i = 0; i < TLBNUM; i++) begin
            if (s0_hit[i]) begin
                s0_ent = entries[i];
            end
            if (s1_hit[i]) begin
                s1_ent = entries[i];
            end
        end
    end

    assign s0_index = encode(s0_hit);
    assign s1_index = encode(s1_hit);
    assign s0_rsp   = make_rsp(s0_req, s0_ent, |s0_hit);
    assign s1_rsp   = make_rsp(s1_req, s1_ent, |s1_hit);

    assign r_entry  = entries[r_index];

    // duplicate mappings are illegal, the encoder relies on that
    always_comb begin
        if (!$isunknown({s0_hit, s1_hit})) begin
            assert #0 ($onehot0(s0_hit))
                else $error("multiple tlb hits on port 0: %b", s0_hit);
            assert #0 ($onehot0(s1_hit))
                else $error("multiple tlb hits on port 1: %b", s1_hit);
        end
    end

endmodule

`default_nettype wire

// File: rtl/tlb_top.sv
`timescale 1ns/100ps
`default_nettype none

module tlb_top import tlb_pkg::*; #(
    parameter  int TLBNUM = 16,
    localparam int IDX_W  = $clog2(TLBNUM)
) (
    input  logic            aclk,
    input  logic            arst_n,
    // search port 0, fetch
    input  tlb_search_req_t s0_req,
    output tlb_search_rsp_t s0_rsp,
    output logic [IDX_W-1:0] s0_index,
    // search port 1, load/store and invtlb operands
    input  tlb_search_req_t s1_req,
    output tlb_search_rsp_t s1_rsp,
    output logic [IDX_W-1:0] s1_index,
    // write port
    input  logic            we,
    input  logic [IDX_W-1:0] w_index,
    input  tlb_entry_t      w_entry,
    // invtlb
    input  logic            inv_valid,
    input  inv_op_t         inv_op,
    // read port
    input  logic [IDX_W-1:0] r_index,
    output tlb_entry_t      r_entry
);
    logic [TLBNUM-1:0] entry_we;
    inv_cmd_t          inv_cmd;
    tlb_entry_t        entries [TLBNUM];
    logic [TLBNUM-1:0] s0_hit;
    logic [TLBNUM-1:0] s1_hit;

    tlb_wr_decode #(
        .TLBNUM    (TLBNUM)
    ) u_wr_decode (
        .we        (we),
        .w_index   (w_index),
        .inv_valid (inv_valid),
        .inv_op    (inv_op),
        .entry_we  (entry_we),
        .inv_cmd   (inv_cmd)
    );

    for (genvar i = 0; i < TLBNUM; i++) begin : g_entry
        tlb_entry u_entry (
            .aclk    (aclk),
            .arst_n  (arst_n),
            .wr      (entry_we[i]),
            .w_entry (w_entry),
            .inv_cmd (inv_cmd),
            .s0_req  (s0_req),
            .s1_req  (s1_req),
            .s0_hit  (s0_hit[i]),
            .s1_hit  (s1_hit[i]),
            .entry   (entries[i])
        );
    end

    tlb_lookup_sel #(
        .TLBNUM   (TLBNUM)
    ) u_lookup_sel (
        .s0_req   (s0_req),
        .s1_req   (s1_req),
        .s0_hit   (s0_hit),
        .s1_hit   (s1_hit),
        .entries  (entries),
        .r_index  (r_index),
        .s0_rsp   (s0_rsp),
        .s0_index (s0_index),
        .s1_rsp   (s1_rsp),
        .s1_index (s1_index),
        .r_entry  (r_entry)
    );

endmodule

`default_nettype wire

// File: tests/tlb_ref_model.svh
`ifndef TLB_REF_MODEL_SVH
`define TLB_REF_MODEL_SVH

// shadow copy of the table, updated in the cycle a write or invtlb is issued
tlb_entry_t        shadow [TLBNUM];
logic [TLBNUM-1:0] written;

function automatic void clear_model();
    for (int i = 0; i < TLBNUM; i++) begin
        shadow[i] = '0;
    end
    written = '0;
endfunction

function automatic void apply_write(input logic [IDX_W-1:0] idx, input tlb_entry_t ent);
    shadow[idx]  = ent;
    written[idx] = 1'b1;
endfunction

// 2M pages compare only the tag above bit 9
function automatic logic page_match(input tlb_entry_t ent, input vppn_t vppn);
    if (ent.ps == PS_2M) begin
        return (ent.vppn >> 9) == (vppn >> 9);
    end
    return ent.vppn == vppn;
endfunction

function automatic tlb_search_rsp_t ref_search(input tlb_search_req_t req,
                                               output logic [IDX_W-1:0] idx);
    tlb_search_rsp_t rsp;
    tlb_page_t       pg;
    logic            odd;
    rsp = '0;
    idx = '0;
    for (int i = 0; i < TLBNUM; i++) begin
        if (shadow[i].e && (shadow[i].g || shadow[i].asid == req.asid) &&
            page_match(shadow[i], req.vppn)) begin
            odd       = (shadow[i].ps == PS_4K) ? req.va_bit12 : req.vppn[8];
            pg        = odd ? shadow[i].page1 : shadow[i].page0;
            rsp.found = 1'b1;
            rsp.ppn   = pg.ppn;
            rsp.ps    = shadow[i].ps;
            rsp.plv   = pg.plv;
            rsp.mat   = pg.mat;
            rsp.d     = pg.d;
            rsp.v     = pg.v;
            idx       = IDX_W'(i);
        end
    end
    return rsp;
endfunction

function automatic void apply_inv(input inv_op_t op, input tlb_search_req_t req);
    logic g;
    logic aeq;
    logic vm;
    logic clr;
    for (int i = 0; i < TLBNUM; i++) begin
        g   = shadow[i].g;
        aeq = (shadow[i].asid == req.asid);
        vm  = page_match(shadow[i], req.vppn);
        case (op)
            5'd0, 5'd1: clr = 1'b1;
            5'd2: clr = g;
            5'd3: clr = !g;
            5'd4: clr = !g && aeq;
            5'd5: clr = !g && aeq && vm;
            5'd6: clr = (g || aeq) && vm;
            default: clr = 1'b0;
        endcase
        if (clr) begin
            shadow[i].e = 1'b0;
        end
    end
endfunction

`endif

// File: tests/tlb_tb.sv
`timescale 1ns/100ps
`default_nettype none

module tlb_tb import tlb_pkg::*; ();

    localparam int TLBNUM       = 16;
    localparam int IDX_W        = $clog2(TLBNUM);
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    // reset, empty sweep, 4K and 2M phases, asid sweep, seven invtlb rounds, drain
    localparam int RUN_CYCLES   = RESET_CYCLES + TLBNUM + 2 * (4 * TLBNUM) + TLBNUM
                                  + 7 * (3 * TLBNUM + 2) + 2;

    logic             aclk;
    logic             arst_n;
    tlb_search_req_t  s0_req;
    tlb_search_req_t  s1_req;
    tlb_search_rsp_t  s0_rsp;
    tlb_search_rsp_t  s1_rsp;
    logic [IDX_W-1:0] s0_index;
    logic [IDX_W-1:0] s1_index;
    logic             we;
    logic [IDX_W-1:0] w_index;
    tlb_entry_t       w_entry;
    logic             inv_valid;
    inv_op_t          inv_op;
    logic [IDX_W-1:0] r_index;
    tlb_entry_t       r_entry;

    integer seed   = 74506;
    int     errors = 0;
    int     checks = 0;

    `include "tlb_ref_model.svh"

    tlb_top #(
        .TLBNUM    (TLBNUM)
    ) UUT (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .s0_req    (s0_req),
        .s0_rsp    (s0_rsp),
        .s0_index  (s0_index),
        .s1_req    (s1_req),
        .s1_rsp    (s1_rsp),
        .s1_index  (s1_index),
        .we        (we),
        .w_index   (w_index),
        .w_entry   (w_entry),
        .inv_valid (inv_valid),
        .inv_op    (inv_op),
        .r_index   (r_index),
        .r_entry   (r_entry)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD * 2);
        $display("run timed out after %0d cycles without finishing", RUN_CYCLES * 2);
        $display("Regression failed");
        $finish;
    end

    task automatic check(input string name, input logic [88:0] exp, input logic [88:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR at %0d ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // unique tag bits [12:9] per index keep every mapping distinct
    function automatic tlb_entry_t make_entry(input int idx, input ps_t ps);
        tlb_entry_t  ent;
        logic [31:0] r;
        r              = $random(seed);
        ent.e          = 1'b1;
        ent.vppn       = r[18:0];
        ent.vppn[12:9] = 4'(idx);
        ent.ps         = ps;
        ent.asid       = {8'd0, r[20:19]};
        ent.g          = r[21];
        r              = $random(seed);
        ent.page0      = r[25:0];
        r              = $random(seed);
        ent.page1      = r[25:0];
        return ent;
    endfunction

    function automatic tlb_search_req_t hit_req(input tlb_entry_t ent, input asid_t asid,
                                                input logic odd);
        tlb_search_req_t req;
        logic [31:0]     r;
        r            = $random(seed);
        req.vppn     = ent.vppn;
        req.va_bit12 = odd;
        req.asid     = asid;
        if (ent.ps == PS_2M) begin
            req.vppn[8:0] = r[8:0];
            req.vppn[8]   = odd;
            req.va_bit12  = r[9];
        end
        return req;
    endfunction

    function automatic tlb_search_req_t rand_req();
        logic [31:0] r;
        r = $random(seed);
        return '{vppn: r[18:0], va_bit12: r[19], asid: r[29:20]};
    endfunction

    // operands aimed at a random entry with a va that is sometimes unrelated
    function automatic tlb_search_req_t inv_operands();
        tlb_search_req_t req;
        logic [31:0]     r;
        r   = $random(seed);
        req = hit_req(shadow[r[3:0]], {8'd0, r[5:4]}, r[6]);
        if (r[7]) begin
            req.vppn = r[26:8];
        end
        return req;
    endfunction

    task automatic search(input tlb_search_req_t req0, input tlb_search_req_t req1,
                          input logic [IDX_W-1:0] ridx);
        @(posedge aclk);
        s0_req  <= req0;
        s1_req  <= req1;
        r_index <= ridx;
    endtask

    task automatic write_entry(input logic [IDX_W-1:0] idx, input tlb_entry_t ent);
        @(posedge aclk);
        we      <= 1'b1;
        w_index <= idx;
        w_entry <= ent;
        r_index <= idx;
        @(posedge aclk);
        we      <= 1'b0;
    endtask

    task automatic invalidate(input inv_op_t op, input tlb_search_req_t req);
        @(posedge aclk);
        inv_valid <= 1'b1;
        inv_op    <= op;
        s1_req    <= req;
        @(posedge aclk);
        inv_valid <= 1'b0;
    endtask

    // mode 0 all 4K, 1 all 2M, 2 mixed
    task automatic fill_table(input int mode);
        logic [31:0] r;
        ps_t         ps;
        for (int i = 0; i < TLBNUM; i++) begin
            r  = $random(seed);
            ps = (mode == 1 || (mode == 2 && r[0])) ? PS_2M : PS_4K;
            write_entry(IDX_W'(i), make_entry(i, ps));
        end
    endtask

    task automatic sweep_hits();
        int j;
        for (int i = 0; i < TLBNUM; i++) begin
            j = TLBNUM - 1 - i;
            for (int odd = 0; odd < 2; odd++) begin
                search(hit_req(shadow[i], shadow[i].asid, odd[0]),
                       hit_req(shadow[j], shadow[j].asid, !odd[0]), IDX_W'(i));
            end
        end
    endtask

    initial begin
        logic [31:0] r;
        s0_req    <= '0;
        s1_req    <= '0;
        we        <= 1'b0;
        w_index   <= '0;
        w_entry   <= '0;
        inv_valid <= 1'b0;
        inv_op    <= '0;
        r_index   <= '0;
        arst_n    <= 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        arst_n <= 1'b1;
        for (int i = 0; i < TLBNUM; i++) begin
            search(rand_req(), rand_req(), IDX_W'(i));
        end
        fill_table(0);
        sweep_hits();
        fill_table(1);
        sweep_hits();
        // foreign asid hits only global entries
        for (int i = 0; i < TLBNUM; i++) begin
            r = $random(seed);
            search(hit_req(shadow[i], shadow[i].asid ^ 10'h200, r[0]),
                   hit_req(shadow[i], shadow[i].asid, r[1]), IDX_W'(i));
        end
        for (int op = 0; op < 7; op++) begin
            fill_table(2);
            invalidate(inv_op_t'(op), inv_operands());
            for (int i = 0; i < TLBNUM; i++) begin
                r = $random(seed);
                search(hit_req(shadow[i], shadow[i].asid, r[0]),
                       hit_req(shadow[i], {8'd0, r[2:1]}, r[3]), IDX_W'(i));
            end
        end
        repeat (2) @(posedge aclk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // compare on the falling edge while inputs are stable
    initial begin
        tlb_search_rsp_t  exp0;
        tlb_search_rsp_t  exp1;
        logic [IDX_W-1:0] idx0;
        logic [IDX_W-1:0] idx1;
        clear_model();
        wait (arst_n === 1'b1);
        forever begin
            @(negedge aclk);
            exp0 = ref_search(s0_req, idx0);
            exp1 = ref_search(s1_req, idx1);
            check("s0_rsp", 89'(exp0), 89'(s0_rsp));
            check("s0_index", 89'(idx0), 89'(s0_index));
            check("s1_rsp", 89'(exp1), 89'(s1_rsp));
            check("s1_index", 89'(idx1), 89'(s1_index));
            if (written[r_index]) begin
                check("r_entry", 89'(shadow[r_index]), 89'(r_entry));
            end else begin
                check("r_entry.e", 89'(shadow[r_index].e), 89'(r_entry.e));
            end
            // table changes at the coming edge
            if (we) begin
                apply_write(w_index, w_entry);
            end
            if (inv_valid) begin
                apply_inv(inv_op, s1_req);
            end
        end
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+tests
rtl/tlb_pkg.sv
rtl/tlb_wr_decode.sv
rtl/tlb_entry.sv
rtl/tlb_lookup_sel.sv
rtl/tlb_top.sv
tests/tlb_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

obj_dir/Vtlb_tb: list.f rtl/*.sv tests/tlb_tb.sv tests/tlb_ref_model.svh
	verilator --binary -f list.f --top-module tlb_tb

test: obj_dir/Vtlb_tb
	@out="$$(./obj_dir/Vtlb_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
